// File: all.f
hdl/wiscPkg.sv
hdl/control.sv
hdl/regFile.sv
hdl/alu.sv
hdl/cpuTop.sv
sim/cpuTb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run, fails unless the pass message appears"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module cpuTb -Mdir obj_dir -f all.f
	@out=$$(./obj_dir/VcpuTb); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// File: sim/cpuTb.sv
// Core testbench with program table, memory models, clock, reset, checks and watchdog
`timescale 1ns/1ns

module cpuTb;
    import wiscPkg::*;

    localparam int numEntries  = 8;
    localparam int progWords   = 16;
    localparam int resetCycles = 10;
    localparam int runBudget   = 200;   // Cycles allowed per entry
    localparam int quietCycles = 5;     // Cycles watched after HALT
    localparam int clkPeriod   = 20;
    localparam int timeLimit   = numEntries * (resetCycles + runBudget + quietCycles) * clkPeriod;

    logic        clk;
    logic        rst;
    logic [15:0] instrAddr;
    logic [15:0] instr;
    logic [15:0] memAddr;
    logic [15:0] memWdata;
    logic        memWe;
    logic        memRe;
    logic [15:0] memRdata;
    logic        halted;
    logic        err;

    logic [15:0] progMem [progWords];
    logic [15:0] dataMem [256];
    logic [15:0] progTable [numEntries][progWords];  // One short program per entry
    logic [15:0] expAddr [numEntries][progWords];
    logic [15:0] expData [numEntries][progWords];
    int          expCount [numEntries];
    logic        expErr [numEntries];
    logic [15:0] gotAddr [$];                        // Stores seen in the current run
    logic [15:0] gotData [$];
    logic [31:0] lcgState;
    int          curEntry;
    int          curPos;
    int          checkCount;
    int          errorCount;
    logic        errSeen;

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    assign instr    = progMem[instrAddr[4:1]];                  // Word index of byte PC
    assign memRdata = memRe ? dataMem[memAddr[7:0]] : 16'h0000;

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                dataMem[i] <= {i[7:0], ~i[7:0]};                // Address-dependent fill
            end
        end else if (memWe) begin
            dataMem[memAddr[7:0]] <= memWdata;
        end
    end

    cpuTop cpuTop_i (
        .clk       (clk),
        .rst       (rst),
        .instrAddr (instrAddr),
        .instr     (instr),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .memWe     (memWe),
        .memRe     (memRe),
        .memRdata  (memRdata),
        .halted    (halted),
        .err       (err)
    );

    function automatic logic [15:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:16];                                 // High bits are the better ones
    endfunction

    function automatic logic [15:0] rotateLeft(logic [15:0] v, logic [3:0] sh);
        return (v << sh) | (v >> (16 - sh));
    endfunction

    function automatic logic [15:0] rotateRight(logic [15:0] v, logic [3:0] sh);
        return (v >> sh) | (v << (16 - sh));
    endfunction

    function automatic logic [15:0] encR(logic [4:0] op, logic [2:0] rs, logic [2:0] rt,
                                         logic [2:0] rd, logic [1:0] fn);
        return {op, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] encI(logic [4:0] op, logic [2:0] rs, logic [2:0] rd,
                                         logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic logic [15:0] encL(logic [4:0] op, logic [2:0] rs, logic [7:0] imm);
        return {op, rs, imm};                                   // LBI, SLBI, branches, JR, JALR
    endfunction

    task automatic checkEq(string name, logic [15:0] got, logic [15:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t ns: entry %0d %s got %h expected %h",
                     $time, curEntry, name, got, exp);
        end
    endtask

    task automatic startEntry(int e);
        curEntry    = e;
        curPos      = 0;
        expCount[e] = 0;
        expErr[e]   = 1'b0;
        for (int w = 0; w < progWords; w++) begin
            progTable[e][w] = {opHalt, 11'd0};                  // Unused words halt
        end
    endtask

    task automatic emit(logic [15:0] word);
        progTable[curEntry][curPos] = word;
        curPos++;
    endtask

    task automatic expectStore(logic [15:0] addr, logic [15:0] data);
        expAddr[curEntry][expCount[curEntry]] = addr;
        expData[curEntry][expCount[curEntry]] = data;
        expCount[curEntry]++;
    endtask

    task automatic loadWord(logic [2:0] rs, logic [15:0] value);
        emit(encL(opLbi, rs, value[15:8]));                     // High byte sign extended
        emit(encL(opSlbi, rs, value[7:0]));                     // Shift up and merge low byte
    endtask

    // Result lands in R3 and ST writes it to R6 (zero) plus slot
    task automatic opAndStore(logic [15:0] word, logic [4:0] slot, logic [15:0] exp);
        emit(word);
        emit(encI(opSt, 3'd6, 3'd3, slot));
        expectStore({11'd0, slot}, exp);
    endtask

    task automatic wrongPathStore();
        emit(encI(opSt, 3'd6, 3'd6, 5'd15));                    // Must never execute
    endtask

    task automatic buildTable();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] r;
        logic [15:0] immS;
        logic [15:0] immZ;
        a = nextRand();
        b = nextRand();
        startEntry(0);                                          // Register arithmetic and logic
        loadWord(3'd1, a);
        loadWord(3'd2, b);
        opAndStore(encR(opArith, 3'd1, 3'd2, 3'd3, fnAdd), 5'd0, a + b);
        opAndStore(encR(opArith, 3'd1, 3'd2, 3'd3, fnSub), 5'd1, b - a);
        opAndStore(encR(opArith, 3'd1, 3'd2, 3'd3, fnXor), 5'd2, a ^ b);
        opAndStore(encR(opArith, 3'd1, 3'd2, 3'd3, fnAndn), 5'd3, a & ~b);
        a    = nextRand();
        r    = nextRand();
        immS = {{11{r[4]}}, r[4:0]};
        immZ = {11'd0, r[4:0]};
        startEntry(1);                                          // Immediate forms
        loadWord(3'd1, a);
        opAndStore(encI(opAddi, 3'd1, 3'd3, r[4:0]), 5'd0, a + immS);
        opAndStore(encI(opSubi, 3'd1, 3'd3, r[4:0]), 5'd1, immS - a);
        opAndStore(encI(opXori, 3'd1, 3'd3, r[4:0]), 5'd2, a ^ immZ);
        opAndStore(encI(opAndni, 3'd1, 3'd3, r[4:0]), 5'd3, a & ~immZ);
        opAndStore(encI(opSlli, 3'd1, 3'd3, r[4:0]), 5'd4, a << r[3:0]);
        opAndStore(encI(opRori, 3'd1, 3'd3, r[4:0]), 5'd5, rotateRight(a, r[3:0]));
        a = nextRand();
        b = nextRand();
        startEntry(2);                                          // Shift amount is low 4 bits of Rt
        loadWord(3'd1, a);
        loadWord(3'd2, b);
        opAndStore(encR(opShift, 3'd1, 3'd2, 3'd3, fnSll), 5'd0, a << b[3:0]);
        opAndStore(encR(opShift, 3'd1, 3'd2, 3'd3, fnSrl), 5'd1, a >> b[3:0]);
        opAndStore(encR(opShift, 3'd1, 3'd2, 3'd3, fnRol), 5'd2, rotateLeft(a, b[3:0]));
        opAndStore(encR(opShift, 3'd1, 3'd2, 3'd3, fnRor), 5'd3, rotateRight(a, b[3:0]));
        a = nextRand();
        b = nextRand();
        r = a + b;                                              // Wraps exactly when a carry leaves
        startEntry(3);                                          // Compares with SLT and SLE signed
        loadWord(3'd1, a);
        loadWord(3'd2, b);
        opAndStore(encR(opSeq, 3'd1, 3'd2, 3'd3, 2'd0), 5'd0, {15'd0, a == b});
        opAndStore(encR(opSlt, 3'd1, 3'd2, 3'd3, 2'd0), 5'd1, {15'd0, $signed(a) < $signed(b)});
        opAndStore(encR(opSle, 3'd1, 3'd2, 3'd3, 2'd0), 5'd2, {15'd0, $signed(a) <= $signed(b)});
        opAndStore(encR(opSco, 3'd1, 3'd2, 3'd3, 2'd0), 5'd3, {15'd0, r < a});
        opAndStore(encR(opSeq, 3'd1, 3'd1, 3'd3, 2'd0), 5'd4, 16'd1);
        a = nextRand();
        startEntry(4);                                          // ST, LD back, STU with base update
        loadWord(3'd1, a);
        emit(encI(opSt, 3'd6, 3'd1, 5'd2));
        expectStore(16'd2, a);
        emit(encI(opLd, 3'd6, 3'd4, 5'd2));
        emit(encI(opSt, 3'd6, 3'd4, 5'd3));
        expectStore(16'd3, a);
        emit(encL(opLbi, 3'd5, 8'd8));
        emit(encI(opStu, 3'd5, 3'd1, 5'd4));                    // mem[12] = a and R5 becomes 12
        expectStore(16'd12, a);
        emit(encI(opSt, 3'd6, 3'd5, 5'd5));
        expectStore(16'd5, 16'd12);
        startEntry(5);                                          // R1 is zero and R2 negative
        emit(encL(opLbi, 3'd2, 8'hFD));
        emit(encL(opLbi, 3'd3, 8'h5A));
        emit(encL(opBeqz, 3'd1, 8'd2));                         // Taken
        wrongPathStore();
        opAndStore(encL(opBnez, 3'd1, 8'd2), 5'd0, 16'h005A);   // Not taken, a jump skips the ST
        emit(encL(opBltz, 3'd2, 8'd2));                         // Taken
        wrongPathStore();
        opAndStore(encL(opBgez, 3'd2, 8'd2), 5'd1, 16'h005A);   // Not taken, a jump skips the ST
        startEntry(6);                                          // Word n sits at byte 2n
        emit({opJ, 11'd2});                                     // 0 -> 4
        wrongPathStore();
        emit({opJal, 11'd2});                                   // 4 -> 8, R7 = 6
        wrongPathStore();
        emit(encI(opSt, 3'd6, 3'd7, 5'd0));
        expectStore(16'd0, 16'd6);
        emit(encL(opLbi, 3'd1, 8'd18));
        emit(encL(opJalr, 3'd1, 8'd0));                         // 12 -> 18, R7 = 14
        wrongPathStore();
        wrongPathStore();
        emit(encI(opSt, 3'd6, 3'd7, 5'd1));
        expectStore(16'd1, 16'd14);
        emit(encL(opLbi, 3'd1, 8'd26));
        emit(encL(opJr, 3'd1, 8'd0));                           // 22 -> 26 without link
        wrongPathStore();
        emit(encI(opSt, 3'd6, 3'd7, 5'd2));
        expectStore(16'd2, 16'd14);
        startEntry(7);                                          // Illegal opcode then HALT
        emit(encL(opLbi, 3'd1, 8'h33));
        emit(encR(opBtr, 3'd1, 3'd1, 3'd1, 2'd0));
        emit(encI(opSt, 3'd6, 3'd1, 5'd0));
        expectStore(16'd0, 16'h0033);
        emit({opHalt, 11'd0});
        wrongPathStore();                                       // Behind HALT
        expErr[7] = 1'b1;
    endtask

    task automatic sampleCycle();
        if (memWe) begin
            gotAddr.push_back(memAddr);
            gotData.push_back(memWdata);
        end
        if (err) begin
            errSeen = 1'b1;
        end
    endtask

    task automatic runEntry(int e);
        curEntry = e;
        @(posedge clk);
        rst <= 1'b1;
        for (int w = 0; w < progWords; w++) begin
            progMem[w] <= progTable[e][w];                      // Loaded while core is held
        end
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        gotAddr.delete();
        gotData.delete();
        errSeen = 1'b0;
        do begin
            @(negedge clk);                                     // Mid-cycle where outputs settled
            sampleCycle();
        end while (!halted);
        repeat (quietCycles) begin
            @(negedge clk);
            sampleCycle();
            checkEq("halted", {15'd0, halted}, 16'd1);
        end
        checkEq("storeCount", 16'(gotAddr.size()), 16'(expCount[e]));
        for (int i = 0; i < gotAddr.size() && i < expCount[e]; i++) begin
            checkEq("memAddr", gotAddr[i], expAddr[e][i]);
            checkEq("memWdata", gotData[i], expData[e][i]);
        end
        checkEq("err", {15'd0, errSeen}, {15'd0, expErr[e]});
    endtask

    initial begin
        rst        <= 1'b1;
        lcgState   = 32'h8f33b2b0;
        checkCount = 0;
        errorCount = 0;
        curEntry   = 0;
        for (int w = 0; w < progWords; w++) begin
            progMem[w] = 16'h0000;
        end
        buildTable();
        for (int e = 0; e < numEntries; e++) begin
            runEntry(e);
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #(timeLimit);
        $display("Timeout: the core never halted in table entry %0d", curEntry);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: hdl/cpuTop.sv
// Single-cycle core top with PC, halt state, immediate extension, next-PC and write-back muxes
`timescale 1ns/1ns

module cpuTop (
    input  logic                          clk,
    input  logic                          rst,
    output logic [wiscPkg::dataWidth-1:0] instrAddr,
    input  logic [wiscPkg::dataWidth-1:0] instr,
    output logic [wiscPkg::dataWidth-1:0] memAddr,
    output logic [wiscPkg::dataWidth-1:0] memWdata,
    output logic                          memWe,
    output logic                          memRe,
    input  logic [wiscPkg::dataWidth-1:0] memRdata,
    output logic                          halted,
    output logic                          err
);
    import wiscPkg::*;

    logic [dataWidth-1:0]    pc;
    logic [dataWidth-1:0]    pcInc;
    logic [dataWidth-1:0]    pcNext;
    logic [dataWidth-1:0]    immExt;
    logic [dataWidth-1:0]    aluInB;
    logic [dataWidth-1:0]    aluResult;
    logic [dataWidth-1:0]    readData1;
    logic [dataWidth-1:0]    readData2;
    logic [dataWidth-1:0]    writeData;
    logic [regAddrWidth-1:0] writeReg;
    logic                    regWriteEn;
    logic                    zFlag;
    logic                    sFlag;

    // Decoder outputs
    logic                regWrite;
    logic [1:0]          dstSel;
    logic                pcSel;
    logic                regJmp;
    logic                memEnable;
    logic                memWr;
    logic [opWidth-1:0]  aluOp;
    logic                val2Reg;
    logic                aluSrcImm;
    logic [2:0]          immSel;
    logic                halt;
    logic [1:0]          linkSel;
    logic                ctrlErr;

    assign instrAddr = pc;
    assign pcInc     = pc + 16'd2;   // Fixed 2-byte instructions

    always_comb begin
        case (immSel)
            immSext5:  immExt = {{(dataWidth-5){instr[4]}}, instr[4:0]};
            immZext5:  immExt = {{(dataWidth-5){1'b0}}, instr[4:0]};
            immSext8:  immExt = {{(dataWidth-8){instr[7]}}, instr[7:0]};
            immZext8:  immExt = {{(dataWidth-8){1'b0}}, instr[7:0]};
            immSext11: immExt = {{(dataWidth-11){instr[10]}}, instr[10:0]};
            default:   immExt = '0;
        endcase
    end

    always_comb begin
        if (regJmp) begin
            pcNext = readData1 + immExt;    // JR, JALR
        end else if (pcSel) begin
            pcNext = pcInc + immExt;        // Taken branch, J, JAL
        end else begin
            pcNext = pcInc;
        end
    end

    always_comb begin
        case (dstSel)
            dstRs:   writeReg = instr[10:8];
            dstRdR:  writeReg = instr[4:2];
            dstR7:   writeReg = linkReg;
            default: writeReg = instr[7:5];  // Rd of I-format
        endcase
    end

    always_comb begin
        case (linkSel)
            linkPc:  writeData = pcInc;      // Return address
            linkLbi: writeData = immExt;
            default: writeData = val2Reg ? memRdata : aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            if (halt) begin
                halted <= 1'b1;              // PC stays on the HALT word
            end else begin
                pc <= pcNext;
            end
        end
    end

    // No state changes while in reset or after HALT
    assign regWriteEn = regWrite & ~halted & ~rst;
    assign memWe      = memEnable & memWr & ~halted & ~rst;
    assign memRe      = memEnable & ~memWr & ~halted & ~rst;
    assign memAddr    = aluResult;           // Rs + sext(imm5)
    assign memWdata   = readData2;           // Rd of ST/STU sits in the Rt field
    assign aluInB     = aluSrcImm ? immExt : readData2;
    assign err        = ctrlErr;

    control control_i (
        .opcode    (instr[15:11]),
        .zFlag     (zFlag),
        .sFlag     (sFlag),
        .regWrite  (regWrite),
        .dstSel    (dstSel),
        .pcSel     (pcSel),
        .regJmp    (regJmp),
        .memEnable (memEnable),
        .memWr     (memWr),
        .aluOp     (aluOp),
        .val2Reg   (val2Reg),
        .aluSrcImm (aluSrcImm),
        .immSel    (immSel),
        .halt      (halt),
        .linkSel   (linkSel),
        .ctrlErr   (ctrlErr)
    );

    regFile regFile_i (
        .clk       (clk),
        .rst       (rst),
        .readReg1  (instr[10:8]),            // Rs
        .readReg2  (instr[7:5]),             // Rt or store data
        .writeReg  (writeReg),
        .writeData (writeData),
        .writeEn   (regWriteEn),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    alu alu_i (
        .aluOp  (aluOp),
        .inA    (readData1),
        .inB    (aluInB),
        .funct  (instr[1:0]),
        .result (aluResult),
        .zFlag  (zFlag),
        .sFlag  (sFlag)
    );

endmodule

// File: hdl/alu.sv
// 16-bit ALU with arithmetic, logic, shifts, rotates, compares, LBI/SLBI and Rs flags
`timescale 1ns/1ns

module alu (
    input  logic [wiscPkg::opWidth-1:0]   aluOp,
    input  logic [wiscPkg::dataWidth-1:0] inA,    // Rs
    input  logic [wiscPkg::dataWidth-1:0] inB,    // Rt or immediate
    input  logic [1:0]                    funct,  // R-format function bits
    output logic [wiscPkg::dataWidth-1:0] result,
    output logic                          zFlag,
    output logic                          sFlag
);
    import wiscPkg::*;

    logic [dataWidth:0]     sum;       // Carry out on top for SCO
    logic [1:0]             arithFn;
    logic [1:0]             shiftFn;
    logic [3:0]             shAmt;
    logic [2*dataWidth-1:0] rotl;
    logic [2*dataWidth-1:0] rotr;
    logic [dataWidth-1:0]   arithRes;
    logic [dataWidth-1:0]   shiftRes;
    logic                   equal;
    logic                   lessThan;

    assign sum      = {1'b0, inA} + {1'b0, inB};
    assign equal    = (inA == inB);
    assign lessThan = ($signed(inA) < $signed(inB));
    assign shAmt    = inB[3:0];
    assign rotl     = {inA, inA} << shAmt;  // Upper half holds the rotated word
    assign rotr     = {inA, inA} >> shAmt;  // Lower half holds it

    // Immediate ops carry the function in their low opcode bits
    assign arithFn = (aluOp == opArith) ? funct : aluOp[1:0];
    assign shiftFn = (aluOp == opShift) ? funct : aluOp[1:0];

    always_comb begin
        case (arithFn)
            fnAdd:   arithRes = sum[dataWidth-1:0];
            fnSub:   arithRes = inB - inA;        // Subtract is B minus A
            fnXor:   arithRes = inA ^ inB;
            default: arithRes = inA & ~inB;       // ANDN
        endcase
    end

    always_comb begin
        case (shiftFn)
            fnRol:   shiftRes = rotl[2*dataWidth-1:dataWidth];
            fnSll:   shiftRes = inA << shAmt;
            fnRor:   shiftRes = rotr[dataWidth-1:0];
            default: shiftRes = inA >> shAmt;     // SRL, zero fill
        endcase
    end

    always_comb begin
        case (aluOp)
            opAddi, opSubi, opXori, opAndni, opArith: result = arithRes;
            opRoli, opSlli, opRori, opSrli, opShift:  result = shiftRes;
            opSeq:   result = {{(dataWidth-1){1'b0}}, equal};
            opSlt:   result = {{(dataWidth-1){1'b0}}, lessThan};
            opSle:   result = {{(dataWidth-1){1'b0}}, lessThan | equal};
            opSco:   result = {{(dataWidth-1){1'b0}}, sum[dataWidth]};
            opLbi:   result = inB;                          // Sign-extended byte
            opSlbi:  result = {inA[dataWidth-9:0], 8'h00} | inB;
            default: result = sum[dataWidth-1:0];           // Address and jump adds
        endcase
    end

    // Branch test looks at Rs only
    assign zFlag = (inA == '0);
    assign sFlag = inA[dataWidth-1];

endmodule

// File: hdl/regFile.sv
// Eight-entry register file, two combinational read ports and one write port
`timescale 1ns/1ns

module regFile (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [wiscPkg::regAddrWidth-1:0] readReg1,
    input  logic [wiscPkg::regAddrWidth-1:0] readReg2,
    input  logic [wiscPkg::regAddrWidth-1:0] writeReg,
    input  logic [wiscPkg::dataWidth-1:0]    writeData,
    input  logic                             writeEn,
    output logic [wiscPkg::dataWidth-1:0]    readData1,
    output logic [wiscPkg::dataWidth-1:0]    readData2
);
    import wiscPkg::*;

    localparam int numRegs = 1 << regAddrWidth; // R0..R7

    logic [dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;                     // Known state for every program
            end
        end else if (writeEn) begin
            regs[writeReg] <= writeData;           // Lands with the PC update
        end
    end

    // Same-cycle write is not seen, the next instruction reads after the edge
    assign readData1 = regs[readReg1];
    assign readData2 = regs[readReg2];

endmodule

// File: hdl/control.sv
// Opcode decoder driving all datapath selects, branch resolution and illegal-opcode flag
`timescale 1ns/1ns

module control (
    input  logic [wiscPkg::opWidth-1:0] opcode,    // instr[15:11]
    input  logic                        zFlag,     // Rs is zero
    input  logic                        sFlag,     // Rs is negative
    output logic                        regWrite,
    output logic [1:0]                  dstSel,
    output logic                        pcSel,     // Take PC+2+imm
    output logic                        regJmp,    // Take Rs+imm
    output logic                        memEnable,
    output logic                        memWr,
    output logic [wiscPkg::opWidth-1:0] aluOp,
    output logic                        val2Reg,   // Write back memory data
    output logic                        aluSrcImm, // ALU B from immediate
    output logic [2:0]                  immSel,
    output logic                        halt,
    output logic [1:0]                  linkSel,
    output logic                        ctrlErr
);
    import wiscPkg::*;

    always_comb begin
        // Safe defaults, an opcode that sets nothing behaves as NOP
        regWrite  = 1'b0;
        dstSel    = dstRdI;
        pcSel     = 1'b0;
        regJmp    = 1'b0;
        memEnable = 1'b0;
        memWr     = 1'b0;
        aluOp     = opcode;       // Most ops hand the opcode straight to the ALU
        val2Reg   = 1'b0;
        aluSrcImm = 1'b1;
        immSel    = immSext5;
        halt      = 1'b0;
        linkSel   = linkNone;
        ctrlErr   = 1'b0;

        case (opcode)
            opHalt: begin
                halt = 1'b1;      // Freeze PC from this edge on
            end
            opNop, opSiic, opRti: begin
                aluOp = opNop;    // Interrupt ops retire without effect
            end
            opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
                regWrite = 1'b1;
                // Arith ops sign extend, logic ops zero extend
                immSel   = opcode[1] ? immZext5 : immSext5;
            end
            opSt, opLd: begin
                aluOp     = opAddi;              // Address is Rs + sext(imm5)
                memEnable = 1'b1;
                memWr     = (opcode == opSt);
                regWrite  = (opcode == opLd);    // Load goes to Rd-I
                val2Reg   = (opcode == opLd);
            end
            opStu: begin
                aluOp     = opAddi;
                memEnable = 1'b1;
                memWr     = 1'b1;
                regWrite  = 1'b1;                // Updated address back to Rs
                dstSel    = dstRs;
            end
            opShift, opArith, opSeq, opSlt, opSle, opSco: begin
                regWrite  = 1'b1;
                dstSel    = dstRdR;
                aluSrcImm = 1'b0;                // B is Rt
                immSel    = immZext5;            // Unused
            end
            opBeqz, opBnez, opBltz, opBgez: begin
                immSel    = immSext8;
                aluSrcImm = 1'b0;
                case (opcode[1:0])
                    2'b00:   pcSel = zFlag;      // BEQZ
                    2'b01:   pcSel = ~zFlag;     // BNEZ
                    2'b10:   pcSel = sFlag;      // BLTZ
                    default: pcSel = ~sFlag;     // BGEZ
                endcase
            end
            opLbi: begin
                regWrite = 1'b1;
                dstSel   = dstRs;
                immSel   = immSext8;
                linkSel  = linkLbi;              // Immediate goes straight to Rs
            end
            opSlbi: begin
                regWrite = 1'b1;
                dstSel   = dstRs;
                immSel   = immZext8;             // (Rs << 8) | zext(imm8)
            end
            opJ, opJal: begin
                aluOp    = opAddi;
                pcSel    = 1'b1;
                immSel   = immSext11;            // PC-relative displacement
                dstSel   = dstR7;
                linkSel  = linkPc;
                regWrite = (opcode == opJal);
            end
            opJr, opJalr: begin
                aluOp    = opAddi;
                regJmp   = 1'b1;                 // Target is Rs + sext(imm8)
                immSel   = immSext8;
                dstSel   = dstR7;
                linkSel  = linkPc;
                regWrite = (opcode == opJalr);
            end
            opBtr: begin
                ctrlErr = 1'b1;                  // Bit reverse not implemented
            end
            default: begin
                ctrlErr = 1'b1;
            end
        endcase
    end

endmodule

// File: hdl/wiscPkg.sv
// ISA widths, opcode map, function codes and datapath select codes
package wiscPkg;

    localparam int dataWidth    = 16; // Word and register width
    localparam int regAddrWidth = 3;  // Eight general registers
    localparam int opWidth      = 5;  // Opcode field is instr[15:11]

    localparam logic [regAddrWidth-1:0] linkReg = 3'd7; // Return address lands in R7

    // Special ops
    localparam logic [opWidth-1:0] opHalt  = 5'b00000;
    localparam logic [opWidth-1:0] opNop   = 5'b00001;
    localparam logic [opWidth-1:0] opSiic  = 5'b00010; // No interrupt support, runs as NOP
    localparam logic [opWidth-1:0] opRti   = 5'b00011; // Same
    // Jumps
    localparam logic [opWidth-1:0] opJ     = 5'b00100;
    localparam logic [opWidth-1:0] opJr    = 5'b00101;
    localparam logic [opWidth-1:0] opJal   = 5'b00110;
    localparam logic [opWidth-1:0] opJalr  = 5'b00111;
    // I-format 1 arithmetic and logic
    localparam logic [opWidth-1:0] opAddi  = 5'b01000;
    localparam logic [opWidth-1:0] opSubi  = 5'b01001;
    localparam logic [opWidth-1:0] opXori  = 5'b01010;
    localparam logic [opWidth-1:0] opAndni = 5'b01011;
    // Branches on Rs
    localparam logic [opWidth-1:0] opBeqz  = 5'b01100;
    localparam logic [opWidth-1:0] opBnez  = 5'b01101;
    localparam logic [opWidth-1:0] opBltz  = 5'b01110;
    localparam logic [opWidth-1:0] opBgez  = 5'b01111;
    // Memory and SLBI
    localparam logic [opWidth-1:0] opSt    = 5'b10000;
    localparam logic [opWidth-1:0] opLd    = 5'b10001;
    localparam logic [opWidth-1:0] opSlbi  = 5'b10010;
    localparam logic [opWidth-1:0] opStu   = 5'b10011;
    // Immediate shifts and rotates
    localparam logic [opWidth-1:0] opRoli  = 5'b10100;
    localparam logic [opWidth-1:0] opSlli  = 5'b10101;
    localparam logic [opWidth-1:0] opRori  = 5'b10110;
    localparam logic [opWidth-1:0] opSrli  = 5'b10111;
    // R-format and LBI
    localparam logic [opWidth-1:0] opLbi   = 5'b11000;
    localparam logic [opWidth-1:0] opBtr   = 5'b11001; // Not built, decodes as illegal
    localparam logic [opWidth-1:0] opShift = 5'b11010; // SLL/SRL/ROL/ROR by funct
    localparam logic [opWidth-1:0] opArith = 5'b11011; // ADD/SUB/XOR/ANDN by funct
    localparam logic [opWidth-1:0] opSeq   = 5'b11100;
    localparam logic [opWidth-1:0] opSlt   = 5'b11101;
    localparam logic [opWidth-1:0] opSle   = 5'b11110;
    localparam logic [opWidth-1:0] opSco   = 5'b11111;

    // R-format function bits, same order as low opcode bits of the I-format ops
    localparam logic [1:0] fnAdd  = 2'b00;
    localparam logic [1:0] fnSub  = 2'b01;
    localparam logic [1:0] fnXor  = 2'b10;
    localparam logic [1:0] fnAndn = 2'b11;
    localparam logic [1:0] fnRol  = 2'b00;
    localparam logic [1:0] fnSll  = 2'b01;
    localparam logic [1:0] fnRor  = 2'b10;
    localparam logic [1:0] fnSrl  = 2'b11;

    // Immediate select, bit 2 is sign, low bits give field size
    localparam logic [2:0] immZext5  = 3'b000;
    localparam logic [2:0] immZext8  = 3'b001;
    localparam logic [2:0] immSext5  = 3'b100;
    localparam logic [2:0] immSext8  = 3'b101;
    localparam logic [2:0] immSext11 = 3'b110;

    // Destination register select
    localparam logic [1:0] dstRs  = 2'b00; // instr[10:8]
    localparam logic [1:0] dstRdR = 2'b01; // instr[4:2]
    localparam logic [1:0] dstR7  = 2'b10;
    localparam logic [1:0] dstRdI = 2'b11; // instr[7:5]

    // Write-back source override
    localparam logic [1:0] linkNone = 2'b00;
    localparam logic [1:0] linkLbi  = 2'b01;
    localparam logic [1:0] linkPc   = 2'b10;

endpackage
